/* source/soc_pkg.sv */
/*
 * SoC fabric package
 * Bus word types, the IO address map and the timing constants that are
 * shared by the switch, the slaves and the top level
 */

package soc_pkg;

  // Bus words and addresses
  typedef logic [15:0] data_t;
  typedef logic [18:0] word_addr_t;
  // IO flag on top of the word address
  typedef logic [19:0] bus_addr_t;
  typedef logic [1:0]  byte_sel_t;

  // Interrupt lines and their numbers
  typedef logic [7:0]  irq_vec_t;
  typedef logic [2:0]  irq_id_t;

  // Board IO
  typedef logic [13:0] led_t;
  typedef logic [9:0]  sw_t;

  // IO 0xf100 - 0xf103
  localparam bus_addr_t GPIO_BASE  = 20'b1_0000_1111_0001_0000_000;
  localparam bus_addr_t GPIO_MASK  = 20'b1_0000_1111_1111_1111_110;

  // IO 0x40 - 0x43
  localparam bus_addr_t TIMER_BASE = 20'b1_0000_0000_0000_0100_000;
  localparam bus_addr_t TIMER_MASK = 20'b1_0000_1111_1111_1111_110;

  // Read data of the default slave
  localparam data_t UNMAPPED_DATA = 16'hffff;

  // Acknowledge vector is this plus the interrupt id
  localparam data_t IRQ_VECTOR_BASE = 16'h0008;

  // Internal reset hold after the external reset is released
  localparam int unsigned RESET_HOLD_CYCLES = 16;
  localparam int unsigned RESET_CNT_W       = $clog2(RESET_HOLD_CYCLES + 1);

  // Interrupt line of the interval timer
  localparam int unsigned TIMER_IRQ = 0;

endpackage

/* source/reset_debounce.sv */
/*
 * Reset debounce
 * Holds the internal reset for a fixed number of clocks after the
 * external reset is released, which also gives a clean power-on reset
 */
`timescale 1ns/100ps

module reset_debounce import soc_pkg::*; (
  input  logic clk,
  input  logic rst_lck,
  output logic rst_o
);

  logic [RESET_CNT_W-1:0] hold_cnt;
  logic [RESET_CNT_W-1:0] hold_cnt_d;

  // Reload while held low, count down once released
  always_comb begin
    if (!rst_lck) begin
      hold_cnt_d = RESET_CNT_W'(RESET_HOLD_CYCLES);
    end else if (hold_cnt != '0) begin
      hold_cnt_d = hold_cnt - 1'b1;
    end else begin
      hold_cnt_d = hold_cnt;
    end
  end

  // Output taken from the next count so it leaves reset on the last tick
  always_ff @(posedge clk) begin
    hold_cnt <= hold_cnt_d;
    rst_o    <= (hold_cnt_d != '0);
  end

endmodule

/* source/bus_switch.sv */
/*
 * Wishbone address switch
 * Decodes the IO flag and word address against the slave map, routes the
 * strobe, returns ack and read data, and answers unmapped accesses itself.
 * During interrupt acknowledge the read data is the interrupt vector.
 */
`timescale 1ns/100ps

module bus_switch import soc_pkg::*; (
  input  logic       clk,
  input  logic       rst_i,

  // Master side
  input  logic       m_io_i,
  input  word_addr_t m_adr_i,
  input  byte_sel_t  m_sel_i,
  input  logic       m_we_i,
  input  logic       m_cyc_i,
  input  logic       m_stb_i,
  input  logic       m_inta_i,
  output data_t      m_dat_o,
  output logic       m_ack_o,

  // Slave returns
  input  data_t      gpio_dat_i,
  input  logic       gpio_ack_i,
  input  data_t      timer_dat_i,
  input  logic       timer_ack_i,

  // Slave strobes
  output logic       gpio_stb_o,
  output logic       timer_stb_o,

  // Current interrupt from the controller
  input  irq_id_t    iid_i
);

  bus_addr_t adr;
  logic      req;
  logic      gpio_sel;
  logic      timer_sel;
  logic      def_sel;
  logic      inta_q;
  irq_id_t   iid_q;
  irq_id_t   iid_cur;

  function automatic logic addr_hit(bus_addr_t a, bus_addr_t base, bus_addr_t mask);
    return (a & mask) == base;
  endfunction

  assign adr = {m_io_i, m_adr_i};
  assign req = m_cyc_i & m_stb_i;

  assign gpio_sel  = addr_hit(adr, GPIO_BASE, GPIO_MASK);
  assign timer_sel = addr_hit(adr, TIMER_BASE, TIMER_MASK);
  assign def_sel   = ~gpio_sel & ~timer_sel;

  assign gpio_stb_o  = req & gpio_sel;
  assign timer_stb_o = req & timer_sel;

  // Default slave acks in the same cycle
  assign m_ack_o = (gpio_sel & gpio_ack_i)
                 | (timer_sel & timer_ack_i)
                 | (req & def_sel);

  // The controller clears the pending bit one cycle into acknowledge,
  // so the id seen on the first cycle is held for the rest of it
  assign iid_cur = inta_q ? iid_q : iid_i;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      inta_q <= 1'b0;
    end else begin
      inta_q <= m_inta_i;
    end
  end

  always_ff @(posedge clk) begin
    iid_q <= iid_cur;
  end

  // Read data mux
  always_comb begin
    if (m_inta_i && !m_we_i) begin
      m_dat_o = IRQ_VECTOR_BASE + data_t'(iid_cur);
    end else if (gpio_sel) begin
      m_dat_o = gpio_dat_i;
    end else if (timer_sel) begin
      m_dat_o = timer_dat_i;
    end else begin
      m_dat_o = UNMAPPED_DATA;
    end
  end

endmodule

/* source/gpio_port.sv */
/*
 * Switches and LEDs port
 * Word 0 reads the board switches, word 1 is the byte-writable LED
 * register, which also reads back
 */
`timescale 1ns/100ps

module gpio_port import soc_pkg::*; (
  input  logic       clk,
  input  logic       rst_i,
  input  logic       stb_i,
  input  logic       we_i,
  input  word_addr_t adr_i,
  input  byte_sel_t  sel_i,
  input  data_t      dat_i,
  input  sw_t        sw_i,
  output data_t      dat_o,
  output logic       ack_o,
  output led_t       leds_o
);

  localparam int unsigned LED_MSB = $bits(led_t) - 1;

  logic access;
  logic led_word;

  // New request only, never in the cycle after an ack
  assign access   = stb_i & ~ack_o;
  assign led_word = adr_i[0];

  always_ff @(posedge clk) begin
    if (rst_i) begin
      ack_o  <= 1'b0;
      leds_o <= '0;
    end else begin
      ack_o <= access;
      if (access && we_i && led_word) begin
        if (sel_i[0]) begin
          leds_o[7:0] <= dat_i[7:0];
        end
        if (sel_i[1]) begin
          leds_o[LED_MSB:8] <= dat_i[LED_MSB:8];
        end
      end
    end
  end

  // Read data, captured with the request
  always_ff @(posedge clk) begin
    if (access) begin
      dat_o <= led_word ? data_t'(leds_o) : data_t'(sw_i);
    end
  end

endmodule

/* source/interval_timer.sv */
/*
 * Interval timer
 * Reloadable down-counter, pulses its interrupt for one cycle every
 * reload+1 clocks, stopped while the reload value is zero
 */
`timescale 1ns/100ps

module interval_timer import soc_pkg::*; (
  input  logic      clk,
  input  logic      rst_i,
  input  logic      stb_i,
  input  logic      we_i,
  input  byte_sel_t sel_i,
  input  data_t     dat_i,
  output data_t     dat_o,
  output logic      ack_o,
  output logic      irq_o
);

  data_t reload;
  data_t reload_d;
  data_t count;
  logic  access;
  logic  wr;

  assign access = stb_i & ~ack_o;
  assign wr     = access & we_i;

  // Byte-lane merge of the written reload value
  always_comb begin
    reload_d = reload;
    if (sel_i[0]) begin
      reload_d[7:0] = dat_i[7:0];
    end
    if (sel_i[1]) begin
      reload_d[15:8] = dat_i[15:8];
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      ack_o  <= 1'b0;
      irq_o  <= 1'b0;
      reload <= '0;
      count  <= '0;
    end else begin
      ack_o <= access;
      irq_o <= 1'b0;
      if (wr) begin
        // Restart the period from the new value
        reload <= reload_d;
        count  <= reload_d;
      end else if (reload == '0) begin
        count <= '0;
      end else if (count == '0) begin
        count <= reload;
        irq_o <= 1'b1;
      end else begin
        count <= count - 1'b1;
      end
    end
  end

  // Reads return the reload register
  always_ff @(posedge clk) begin
    if (access) begin
      dat_o <= reload;
    end
  end

endmodule

/* source/irq_controller.sv */
/*
 * Priority interrupt controller
 * Rising edges set pending bits, the lowest pending line is reported, and
 * a rising edge of acknowledge clears that line
 */
`timescale 1ns/100ps

module irq_controller import soc_pkg::*; (
  input  logic     clk,
  input  logic     rst_i,
  input  irq_vec_t irq_i,
  input  logic     inta_i,
  output logic     intr_o,
  output irq_id_t  iid_o
);

  irq_vec_t irq_q;
  irq_vec_t rise;
  irq_vec_t clr;
  irq_vec_t pending;
  logic     inta_q;

  assign rise = irq_i & ~irq_q;

  // Lowest numbered pending line wins
  always_comb begin
    iid_o = '0;
    for (int i = $bits(irq_vec_t) - 1; i >= 0; i--) begin
      if (pending[i]) begin
        iid_o = irq_id_t'(i);
      end
    end
  end

  // Clear mask for the line being acknowledged
  always_comb begin
    clr = '0;
    if (inta_i && !inta_q) begin
      clr = irq_vec_t'(1) << iid_o;
    end
  end

  assign intr_o = |pending;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      irq_q   <= '0;
      inta_q  <= 1'b0;
      pending <= '0;
    end else begin
      irq_q   <= irq_i;
      inta_q  <= inta_i;
      // A fresh edge on the acknowledged line keeps it pending
      pending <= (pending & ~clr) | rise;
    end
  end

endmodule

/* source/soc_fabric.sv */
/*
 * SoC bus fabric
 * Reset debounce, address switch, GPIO port, interval timer and interrupt
 * controller around an external Wishbone master port
 */
`timescale 1ns/100ps

module soc_fabric import soc_pkg::*; (
  input  logic       clk,
  input  logic       rst_lck,

  // Master bus
  input  word_addr_t m_adr_i,
  input  logic       m_io_i,
  input  data_t      m_dat_i,
  input  byte_sel_t  m_sel_i,
  input  logic       m_we_i,
  input  logic       m_cyc_i,
  input  logic       m_stb_i,
  output data_t      m_dat_o,
  output logic       m_ack_o,

  // Interrupts, the timer owns the line below the external ones
  input  logic       m_inta_i,
  output logic       m_intr_o,
  input  logic [$bits(irq_vec_t)-1:TIMER_IRQ+1] irq_i,

  // Board IO
  input  sw_t        sw_i,
  output led_t       leds_o
);

  logic    rst;
  logic    gpio_stb;
  logic    gpio_ack;
  data_t   gpio_dat;
  logic    timer_stb;
  logic    timer_ack;
  data_t   timer_dat;
  logic    timer_irq;
  irq_id_t iid;

  reset_debounce i_reset (
    .clk     (clk),
    .rst_lck (rst_lck),
    .rst_o   (rst)
  );

  bus_switch i_switch (
    .clk         (clk),
    .rst_i       (rst),
    .m_io_i      (m_io_i),
    .m_adr_i     (m_adr_i),
    .m_sel_i     (m_sel_i),
    .m_we_i      (m_we_i),
    .m_cyc_i     (m_cyc_i),
    .m_stb_i     (m_stb_i),
    .m_inta_i    (m_inta_i),
    .m_dat_o     (m_dat_o),
    .m_ack_o     (m_ack_o),
    .gpio_dat_i  (gpio_dat),
    .gpio_ack_i  (gpio_ack),
    .timer_dat_i (timer_dat),
    .timer_ack_i (timer_ack),
    .gpio_stb_o  (gpio_stb),
    .timer_stb_o (timer_stb),
    .iid_i       (iid)
  );

  // Write data, address, select and we are shared by all slaves
  gpio_port i_gpio (
    .clk    (clk),
    .rst_i  (rst),
    .stb_i  (gpio_stb),
    .we_i   (m_we_i),
    .adr_i  (m_adr_i),
    .sel_i  (m_sel_i),
    .dat_i  (m_dat_i),
    .sw_i   (sw_i),
    .dat_o  (gpio_dat),
    .ack_o  (gpio_ack),
    .leds_o (leds_o)
  );

  interval_timer i_timer (
    .clk   (clk),
    .rst_i (rst),
    .stb_i (timer_stb),
    .we_i  (m_we_i),
    .sel_i (m_sel_i),
    .dat_i (m_dat_i),
    .dat_o (timer_dat),
    .ack_o (timer_ack),
    .irq_o (timer_irq)
  );

  irq_controller i_pic (
    .clk    (clk),
    .rst_i  (rst),
    .irq_i  ({irq_i, timer_irq}),
    .inta_i (m_inta_i),
    .intr_o (m_intr_o),
    .iid_o  (iid)
  );

endmodule

/* testbench/tb_soc_fabric.sv */
/*
 * SoC fabric testbench
 * Acts as the bus master, checks GPIO, default slave, interrupt
 * controller and timer against a reference model of the address map
 */
`timescale 1ns/100ps

module tb_soc_fabric import soc_pkg::*; ();

  localparam int unsigned RESET_CYCLES    = 10;
  localparam int unsigned ACK_TIMEOUT     = 8;
  localparam int unsigned SETTLE_NS       = 10;
  localparam int unsigned NUM_TESTS       = 5;
  localparam int unsigned WATCHDOG_CYCLES = NUM_TESTS * 200;
  localparam int unsigned LOOPS           = 8;
  localparam int unsigned QUIET_CYCLES    = 150;

  // Word addresses are byte addresses shifted right by one
  localparam word_addr_t SW_ADR    = 19'h07880;  // 0xf100
  localparam word_addr_t LED_ADR   = 19'h07881;  // 0xf102
  localparam word_addr_t TIMER_ADR = 19'h00020;  // 0x40

  logic       clk;
  logic       rst_lck;
  word_addr_t m_adr_i;
  logic       m_io_i;
  data_t      m_dat_i;
  byte_sel_t  m_sel_i;
  logic       m_we_i;
  logic       m_cyc_i;
  logic       m_stb_i;
  data_t      m_dat_o;
  logic       m_ack_o;
  logic       m_inta_i;
  logic       m_intr_o;
  logic [7:1] irq_i;
  sw_t        sw_i;
  led_t       leds_o;

  // Reference model state
  sw_t      sw_model;
  led_t     led_model;
  data_t    reload_model;
  irq_vec_t pend_model;

  soc_fabric i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic abort_run();
    $display("Checks failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_value(input string name, input data_t expected, input data_t actual);
    if (actual !== expected) begin
      $display("FAIL %s: expected %h, actual %h", name, expected, actual);
      abort_run();
    end
  endtask

  function automatic logic is_mapped(input logic io, input word_addr_t adr);
    logic [19:0] byte_adr;
    byte_adr = {adr, 1'b0};
    return io && ((byte_adr >= 20'hf100 && byte_adr <= 20'hf103) ||
                  (byte_adr >= 20'h00040 && byte_adr <= 20'h00043));
  endfunction

  function automatic int lowest_pending();
    int idx;
    idx = -1;
    for (int i = 0; i < $bits(irq_vec_t); i++) begin
      if (pend_model[i] && idx < 0) begin
        idx = i;
      end
    end
    return idx;
  endfunction

  // Expected read data from the map and the models
  function automatic data_t expected_read(input logic io, input word_addr_t adr,
                                          input logic inta);
    if (inta) return IRQ_VECTOR_BASE + data_t'(lowest_pending());
    if (io && adr == SW_ADR) return data_t'(sw_model);
    if (io && adr == LED_ADR) return data_t'(led_model);
    if (io && adr == TIMER_ADR) return reload_model;
    return UNMAPPED_DATA;
  endfunction

  task automatic bus_access(input string name, input logic io, input word_addr_t adr,
                            input logic we, input byte_sel_t sel, input data_t wdat,
                            input logic inta, output data_t rdat);
    int lat;
    int exp_lat;
    exp_lat = is_mapped(io, adr) ? 1 : 0;
    @(negedge clk);
    m_io_i   = io;
    m_adr_i  = adr;
    m_we_i   = we;
    m_sel_i  = sel;
    m_dat_i  = wdat;
    m_inta_i = inta;
    m_cyc_i  = 1'b1;
    m_stb_i  = 1'b1;
    #(SETTLE_NS);
    lat = 0;
    while (!m_ack_o) begin
      if (lat >= int'(ACK_TIMEOUT)) begin
        $display("%s: no ack from the bus within %0d cycles", name, ACK_TIMEOUT);
        abort_run();
      end
      @(negedge clk);
      lat++;
    end
    rdat = m_dat_o;
    check_value({name, " ack latency"}, data_t'(exp_lat), data_t'(lat));
    // Same-cycle ack still holds the request up to the clock edge
    if (lat == 0) begin
      @(negedge clk);
    end
    m_cyc_i  = 1'b0;
    m_stb_i  = 1'b0;
    m_we_i   = 1'b0;
    m_inta_i = 1'b0;
  endtask

  task automatic read_check(input string name, input logic io, input word_addr_t adr,
                            input logic inta);
    data_t exp;
    data_t rd;
    exp = expected_read(io, adr, inta);
    bus_access(name, io, adr, 1'b0, 2'b11, '0, inta, rd);
    check_value(name, exp, rd);
  endtask

  task automatic write_bus(input string name, input logic io, input word_addr_t adr,
                           input byte_sel_t sel, input data_t dat);
    data_t rd;
    bus_access(name, io, adr, 1'b1, sel, dat, 1'b0, rd);
    if (io && adr == LED_ADR) begin
      if (sel[0]) led_model[7:0] = dat[7:0];
      if (sel[1]) led_model[13:8] = dat[13:8];
    end else if (io && adr == TIMER_ADR) begin
      if (sel[0]) reload_model[7:0] = dat[7:0];
      if (sel[1]) reload_model[15:8] = dat[15:8];
    end
  endtask

  // Acknowledge cycle, then the served line leaves the model
  task automatic ack_irq(input string name);
    read_check(name, 1'b0, '0, 1'b1);
    pend_model[lowest_pending()] = 1'b0;
  endtask

  task automatic wait_intr(input string name, input int max_cycles);
    int n;
    n = 0;
    while (!m_intr_o) begin
      if (n >= max_cycles) begin
        $display("%s: no interrupt request within %0d cycles", name, max_cycles);
        abort_run();
      end
      @(negedge clk);
      n++;
    end
  endtask

  task automatic gpio_readback();
    for (int i = 0; i < int'(LOOPS); i++) begin
      @(negedge clk);
      sw_model = sw_t'($urandom);
      sw_i     = sw_model;
      read_check("switch read", 1'b1, SW_ADR, 1'b0);
    end
    for (int i = 0; i < int'(LOOPS); i++) begin
      write_bus("led write", 1'b1, LED_ADR, byte_sel_t'($urandom_range(0, 3)),
                data_t'($urandom));
      check_value("leds output", data_t'(led_model), data_t'(leds_o));
      read_check("led readback", 1'b1, LED_ADR, 1'b0);
    end
  endtask

  task automatic unmapped_access();
    logic       io;
    word_addr_t adr;
    for (int i = 0; i < int'(LOOPS); i++) begin
      io = 1'($urandom_range(0, 1));
      // IO space is 16 bits wide
      do begin
        adr = io ? word_addr_t'($urandom_range(0, 32'h7fff)) : word_addr_t'($urandom);
      end while (is_mapped(io, adr));
      read_check("unmapped read", io, adr, 1'b0);
      write_bus("unmapped write", io, adr, byte_sel_t'($urandom_range(0, 3)),
                data_t'($urandom));
    end
    check_value("leds after unmapped writes", data_t'(led_model), data_t'(leds_o));
    read_check("led readback after unmapped writes", 1'b1, LED_ADR, 1'b0);
    read_check("timer reload after unmapped writes", 1'b1, TIMER_ADR, 1'b0);
  endtask

  task automatic irq_priority();
    logic [7:1] lines;
    for (int r = 0; r < 4; r++) begin
      lines = 7'($urandom_range(1, 127));
      @(negedge clk);
      irq_i = lines;
      @(negedge clk);
      irq_i = '0;
      pend_model = pend_model | {lines, 1'b0};
      while (pend_model != '0) begin
        check_value("intr while pending", 16'd1, data_t'(m_intr_o));
        ack_irq("irq vector");
      end
      check_value("intr after all served", 16'd0, data_t'(m_intr_o));
    end
  endtask

  task automatic timer_period();
    data_t n;
    n = data_t'($urandom_range(5, 30));
    write_bus("timer reload write", 1'b1, TIMER_ADR, 2'b11, n);
    read_check("timer reload read", 1'b1, TIMER_ADR, 1'b0);
    for (int k = 0; k < 2; k++) begin
      wait_intr("timer interrupt", int'(n) + 8);
      pend_model[TIMER_IRQ] = 1'b1;
      ack_irq("timer vector");
    end
    write_bus("timer stop", 1'b1, TIMER_ADR, 2'b11, '0);
    read_check("timer stopped reload", 1'b1, TIMER_ADR, 1'b0);
    repeat (QUIET_CYCLES) begin
      @(negedge clk);
      check_value("no timer interrupt after stop", 16'd0, data_t'(m_intr_o));
    end
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    abort_run();
  end

  initial begin
    void'($urandom(32'hfcf2));
    rst_lck      = 1'b0;
    m_adr_i      = '0;
    m_io_i       = 1'b0;
    m_dat_i      = '0;
    m_sel_i      = '0;
    m_we_i       = 1'b0;
    m_cyc_i      = 1'b0;
    m_stb_i      = 1'b0;
    m_inta_i     = 1'b0;
    irq_i        = '0;
    sw_i         = '0;
    sw_model     = '0;
    led_model    = '0;
    reload_model = '0;
    pend_model   = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_lck = 1'b1;
    repeat (RESET_HOLD_CYCLES + 4) @(negedge clk);

    check_value("leds after reset", 16'd0, data_t'(leds_o));
    check_value("intr after reset", 16'd0, data_t'(m_intr_o));
    check_value("ack without request", 16'd0, data_t'(m_ack_o));

    gpio_readback();
    unmapped_access();
    irq_priority();
    timer_period();

    $display("All checks passed");
    $finish;
  end

endmodule

/* all.f */
source/soc_pkg.sv
source/reset_debounce.sv
source/bus_switch.sv
source/gpio_port.sv
source/interval_timer.sv
source/irq_controller.sv
source/soc_fabric.sv
testbench/tb_soc_fabric.sv

/* run.sh */
#!/usr/bin/env bash
# Build the SoC fabric testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_soc_fabric -f all.f

sim_out="$(./obj_dir/Vtb_soc_fabric 2>&1)" || true
echo "$sim_out"

if grep -q "All checks passed" <<< "$sim_out"; then
  exit 0
fi
exit 1
